/* design/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Operand width of the execute stage
`define ALU_DATA_WIDTH 32

// Opcode field width, matches the enum in aluPkg
`define ALU_OP_WIDTH 5

// Restoring divider produces one quotient bit per step
`define ALU_DIV_STEPS `ALU_DATA_WIDTH

`endif

/* design/aluPkg.sv */
`default_nettype none

`include "alu_config.svh"

package aluPkg;

  // Opcode encodings shared with the decode stage
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ADD    = 5'b00000,
    ADC    = 5'b00001,
    QADD   = 5'b00010,
    SUB    = 5'b00011,
    SBC    = 5'b00100,
    RSB    = 5'b00101,
    QSUB   = 5'b00110,
    MUL    = 5'b00111,
    UDIV   = 5'b01110,
    SDIV   = 5'b01111,
    AND_OP = 5'b10000,
    BIC    = 5'b10001,
    ORR    = 5'b10010,
    ORN    = 5'b10011,
    EOR    = 5'b10100,
    CMN    = 5'b10101,
    TST    = 5'b10110,
    TEQ    = 5'b10111,
    CMP    = 5'b11000,
    MOV    = 5'b11001,
    RSHIFT = 5'b11010,
    ASHIFT = 5'b11011,
    LSHIFT = 5'b11100,
    ROR    = 5'b11101,
    RRX    = 5'b11110
  } aluOpT;

  // Status flags, q is the sticky saturation bit
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
    logic q;
  } flagsT;

  typedef struct packed {
    aluOpT                     op;
    logic [`ALU_DATA_WIDTH-1:0] a;
    logic [`ALU_DATA_WIDTH-1:0] b;
    logic                      setFlags;
  } execReqT;

  typedef struct packed {
    logic [2*`ALU_DATA_WIDTH-1:0] result;
    flagsT                        flags;
  } execRspT;

  // Datapath to top level bundle
  typedef struct packed {
    logic [2*`ALU_DATA_WIDTH-1:0] result;
    flagsT                        flags;
  } aluOutT;

endpackage

`default_nettype wire

/* design/alu.sv */
`default_nettype none

`include "alu_config.svh"

module alu (
  input  aluPkg::aluOpT              op,
  input  logic [`ALU_DATA_WIDTH-1:0] a,
  input  logic [`ALU_DATA_WIDTH-1:0] b,
  input  aluPkg::flagsT              flagsIn,
  output aluPkg::aluOutT             out
);

  localparam int W  = `ALU_DATA_WIDTH;
  localparam int SW = $clog2(W);
  localparam logic [W-1:0] SAT_MAX = {1'b0, {(W-1){1'b1}}};
  localparam logic [W-1:0] SAT_MIN = {1'b1, {(W-1){1'b0}}};

  logic [SW-1:0]  shiftAmount;
  logic [W-1:0]   addA;
  logic [W-1:0]   addB;
  logic           addCin;
  logic [W:0]     sum;
  logic           addOverflow;
  logic [W:0]     lslExt;
  logic [W:0]     lsrExt;
  logic [W:0]     asrExt;
  logic [2*W-1:0] rorExt;
  logic [2*W-1:0] product;
  logic [W-1:0]   r;
  logic           carryNext;
  logic           overflowNext;
  logic           saturate;

  // One adder serves the whole add and subtract group
  // Subtraction is a + ~b + carry, so the carry out is NOT borrow
  always_comb begin
    addA   = a;
    addB   = b;
    addCin = 1'b0;
    case (op)
      aluPkg::ADC: addCin = flagsIn.c;
      aluPkg::SUB, aluPkg::QSUB, aluPkg::CMP: begin
        addB   = ~b;
        addCin = 1'b1;
      end
      aluPkg::SBC: begin
        addB   = ~b;
        addCin = flagsIn.c;
      end
      aluPkg::RSB: begin
        addA   = b;
        addB   = ~a;
        addCin = 1'b1;
      end
      default: begin
        addCin = 1'b0;
      end
    endcase
  end

  assign sum         = {1'b0, addA} + {1'b0, addB} + {{W{1'b0}}, addCin};
  assign addOverflow = (addA[W-1] == addB[W-1]) && (sum[W-1] != addA[W-1]);

  // Shift amount comes from the low bits of b
  assign shiftAmount = b[SW-1:0];

  // Extra bit on each shifter catches the last bit shifted out
  assign lslExt  = {1'b0, a} << shiftAmount;
  assign lsrExt  = {a, 1'b0} >> shiftAmount;
  assign asrExt  = $signed({a, 1'b0}) >>> shiftAmount;
  assign rorExt  = {a, a} >> shiftAmount;
  assign product = {{W{1'b0}}, a} * {{W{1'b0}}, b};

  always_comb begin
    r            = '0;
    carryNext    = flagsIn.c;
    overflowNext = flagsIn.v;
    saturate     = 1'b0;
    case (op)
      aluPkg::ADD, aluPkg::ADC, aluPkg::SUB, aluPkg::SBC,
      aluPkg::RSB, aluPkg::CMN, aluPkg::CMP: begin
        r            = sum[W-1:0];
        carryNext    = sum[W];
        overflowNext = addOverflow;
      end
      // Saturating forms leave C and V as they were
      aluPkg::QADD, aluPkg::QSUB: begin
        saturate = addOverflow;
        if (!addOverflow) begin
          r = sum[W-1:0];
        end else begin
          r = addA[W-1] ? SAT_MIN : SAT_MAX;
        end
      end
      aluPkg::MUL:                 r = product[W-1:0];
      aluPkg::AND_OP, aluPkg::TST: r = a & b;
      aluPkg::BIC:                 r = a & ~b;
      aluPkg::ORR:                 r = a | b;
      aluPkg::ORN:                 r = a | ~b;
      aluPkg::EOR, aluPkg::TEQ:    r = a ^ b;
      aluPkg::MOV:                 r = b;
      aluPkg::LSHIFT: begin
        r = lslExt[W-1:0];
        if (shiftAmount != '0) carryNext = lslExt[W];
      end
      aluPkg::RSHIFT: begin
        r = lsrExt[W:1];
        if (shiftAmount != '0) carryNext = lsrExt[0];
      end
      aluPkg::ASHIFT: begin
        r = asrExt[W:1];
        if (shiftAmount != '0) carryNext = asrExt[0];
      end
      aluPkg::ROR: begin
        r = rorExt[W-1:0];
        // Last bit rotated out lands in the MSB
        if (shiftAmount != '0) carryNext = rorExt[W-1];
      end
      aluPkg::RRX: begin
        r         = {flagsIn.c, a[W-1:1]};
        carryNext = a[0];
      end
      // Divides are served by the divider
      default: r = '0;
    endcase
  end

  always_comb begin
    out.result  = (op == aluPkg::MUL) ? product : {{W{1'b0}}, r};
    out.flags.n = r[W-1];
    out.flags.z = (r == '0);
    out.flags.c = carryNext;
    out.flags.v = overflowNext;
    out.flags.q = flagsIn.q | saturate;
  end

endmodule

`default_nettype wire

/* design/divider.sv */
`default_nettype none

`include "alu_config.svh"

module divider (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       start,
  input  logic                       signedDiv,
  input  logic [`ALU_DATA_WIDTH-1:0] dividend,
  input  logic [`ALU_DATA_WIDTH-1:0] divisor,
  output logic                       busy,
  output logic                       done,
  output logic [`ALU_DATA_WIDTH-1:0] quotient
);

  localparam int W     = `ALU_DATA_WIDTH;
  localparam int STEPS = `ALU_DIV_STEPS;
  localparam int CW    = $clog2(STEPS + 1);

  logic [W-1:0]  remReg;
  logic [W-1:0]  quoReg;
  logic [W-1:0]  dvsrReg;
  logic          negReg;
  logic          zeroReg;
  logic [CW-1:0] stepsLeft;
  logic          lastStep;
  logic [W-1:0]  dividendMag;
  logic [W-1:0]  divisorMag;
  logic [W-1:0]  stepRemIn;
  logic [W-1:0]  stepQuoIn;
  logic [W-1:0]  stepDvsr;
  logic [W:0]    shifted;
  logic [W+1:0]  trial;
  logic [W-1:0]  stepRem;
  logic [W-1:0]  stepQuo;

  assign dividendMag = (signedDiv && dividend[W-1]) ? -dividend : dividend;
  assign divisorMag  = (signedDiv && divisor[W-1]) ? -divisor : divisor;

  // The start cycle already runs the first step on the fresh operands
  assign stepRemIn = start ? '0 : remReg;
  assign stepQuoIn = start ? dividendMag : quoReg;
  assign stepDvsr  = start ? divisorMag : dvsrReg;

  assign shifted = {stepRemIn, stepQuoIn[W-1]};
  assign trial   = {1'b0, shifted} - {2'b00, stepDvsr};

  // Restore on borrow, otherwise keep the difference
  always_comb begin
    if (trial[W+1]) begin
      stepRem = shifted[W-1:0];
      stepQuo = {stepQuoIn[W-2:0], 1'b0};
    end else begin
      stepRem = trial[W-1:0];
      stepQuo = {stepQuoIn[W-2:0], 1'b1};
    end
  end

  assign lastStep = busy && (stepsLeft == CW'(1));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      stepsLeft <= '0;
    end else begin
      done <= lastStep;
      if (start) begin
        busy      <= 1'b1;
        stepsLeft <= CW'(STEPS - 1);
      end else if (busy) begin
        stepsLeft <= stepsLeft - 1'b1;
        if (lastStep) busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start || busy) begin
      remReg <= stepRem;
      quoReg <= stepQuo;
    end
    if (start) begin
      dvsrReg <= divisorMag;
      negReg  <= signedDiv && (dividend[W-1] ^ divisor[W-1]);
      zeroReg <= (divisor == '0);
    end
    // Sign applied as the last bit comes out, zero for a zero divisor
    if (lastStep) begin
      quotient <= zeroReg ? '0 : (negReg ? -stepQuo : stepQuo);
    end
  end

  noStartWhileBusy: assert property (@(posedge clk) disable iff (!rstN) start |-> !busy)
    else $error("divider: start raised while a division is running");

endmodule

`default_nettype wire

/* design/statusRegister.sv */
`default_nettype none

module statusRegister (
  input  logic          clk,
  input  logic          rstN,
  input  logic          update,
  input  logic          setFlags,
  input  aluPkg::flagsT flagsNext,
  output aluPkg::flagsT flags
);

  logic load;

  // Flags move only for ops that ask for it
  assign load = update && setFlags;

  // The datapath reads flags directly for carry-in and pass-through
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (load) begin
      flags.n <= flagsNext.n;
      flags.z <= flagsNext.z;
      flags.c <= flagsNext.c;
      flags.v <= flagsNext.v;
      // Saturation is sticky until reset
      flags.q <= flags.q | flagsNext.q;
    end
  end

endmodule

`default_nettype wire

/* design/execUnit.sv */
`default_nettype none

`include "alu_config.svh"

module execUnit (
  input  logic            clk,
  input  logic            rstN,
  input  logic            req,
  input  aluPkg::execReqT reqData,
  output logic            ack,
  output aluPkg::execRspT rspData
);

  localparam int W = `ALU_DATA_WIDTH;

  typedef enum logic [1:0] {
    IDLE,
    COMPUTE,
    RESPOND,
    RELEASE
  } stateT;

  stateT           state;
  aluPkg::execReqT reqQ;
  aluPkg::aluOutT  aluOut;
  aluPkg::flagsT   flags;
  aluPkg::flagsT   divFlags;
  aluPkg::flagsT   flagsNext;
  logic            isDiv;
  logic            divStart;
  logic            divIssued;
  logic            divDone;
  logic [W-1:0]    quotient;
  logic            resultReady;

  assign isDiv    = (reqQ.op == aluPkg::UDIV) || (reqQ.op == aluPkg::SDIV);
  assign divStart = (state == COMPUTE) && isDiv && !divIssued;

  // Doubles as the status update strobe on the ack edge
  assign resultReady = (state == COMPUTE) && (!isDiv || divDone);

  // Divides only touch N and Z
  always_comb begin
    divFlags   = flags;
    divFlags.n = quotient[W-1];
    divFlags.z = (quotient == '0);
  end

  assign flagsNext = isDiv ? divFlags : aluOut.flags;

  alu uAlu (
    .op      (reqQ.op),
    .a       (reqQ.a),
    .b       (reqQ.b),
    .flagsIn (flags),
    .out     (aluOut)
  );

  divider uDivider (
    .clk       (clk),
    .rstN      (rstN),
    .start     (divStart),
    .signedDiv (reqQ.op == aluPkg::SDIV),
    .dividend  (reqQ.a),
    .divisor   (reqQ.b),
    .busy      (),
    .done      (divDone),
    .quotient  (quotient)
  );

  statusRegister uStatus (
    .clk       (clk),
    .rstN      (rstN),
    .update    (resultReady),
    .setFlags  (reqQ.setFlags),
    .flagsNext (flagsNext),
    .flags     (flags)
  );

  // Four-phase handshake controller
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= IDLE;
      ack       <= 1'b0;
      divIssued <= 1'b0;
      reqQ      <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            reqQ      <= reqData;
            divIssued <= 1'b0;
            state     <= COMPUTE;
          end
        end
        COMPUTE: begin
          if (divStart) divIssued <= 1'b1;
          if (resultReady) begin
            ack   <= 1'b1;
            state <= RESPOND;
          end
        end
        // Hold ack and data while the requester keeps req up
        RESPOND: if (!req) state <= RELEASE;
        RELEASE: begin
          ack   <= 1'b0;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (resultReady) begin
      rspData.result <= isDiv ? {{W{1'b0}}, quotient} : aluOut.result;
      rspData.flags  <= reqQ.setFlags ? flagsNext : flags;
    end
  end

  ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> $past(req))
    else $error("execUnit: ack rose without a pending req");

  reqDataHeld: assert property (@(posedge clk) disable iff (!rstN)
    (req && !ack) |=> $stable(reqData))
    else $error("execUnit: reqData changed before ack");

endmodule

`default_nettype wire

/* verif/execUnitTb.sv */
`default_nettype none

`include "alu_config.svh"

module execUnitTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int W = `ALU_DATA_WIDTH;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_OPS = 400;
  localparam real TIMEOUT_NS =
    10.0 * (MAX_OPS * (`ALU_DIV_STEPS + 20) + 3 * RESET_CYCLES + 200);
  localparam longint MAX_U = (longint'(1) << W) - 1;
  localparam longint MAX_S = (longint'(1) << (W - 1)) - 1;
  localparam longint MIN_S = -(longint'(1) << (W - 1));

  logic            clk;
  logic            rstN;
  logic            req;
  aluPkg::execReqT reqData;
  logic            ack;
  aluPkg::execRspT rspData;

  aluPkg::flagsT   modelFlags;
  aluPkg::execRspT expected[$];
  aluPkg::execRspT heldRsp;
  logic            ackPrev;
  integer          seed = 60413;
  int              errors = 0;
  int              requests = 0;
  int              responses = 0;

  logic [W-1:0] edgeVals [7] = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000,
                                 32'hffffffff, 32'hfffffffe, 32'h80000001};
  logic [W-1:0] shiftAmts [3] = '{32'd0, 32'd1, 32'd31};
  aluPkg::aluOpT addOps [7] = '{aluPkg::ADD, aluPkg::ADC, aluPkg::SUB, aluPkg::SBC,
                                aluPkg::RSB, aluPkg::CMN, aluPkg::CMP};
  aluPkg::aluOpT logicOps [8] = '{aluPkg::AND_OP, aluPkg::BIC, aluPkg::ORR, aluPkg::ORN,
                                  aluPkg::EOR, aluPkg::TST, aluPkg::TEQ, aluPkg::MOV};
  aluPkg::aluOpT shiftOps [5] = '{aluPkg::LSHIFT, aluPkg::RSHIFT, aluPkg::ASHIFT,
                                  aluPkg::ROR, aluPkg::RRX};

  execUnit uut (
    .clk     (clk),
    .rstN    (rstN),
    .req     (req),
    .reqData (reqData),
    .ack     (ack),
    .rspData (rspData)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Exact add or subtract where the carry of a subtract is NOT borrow
  function automatic void addSub(input longint x, input longint y, input longint sx,
      input longint sy, input longint cin, input bit sub,
      output logic [W-1:0] r, output logic c, output logic v);
    longint wide;
    longint exact;
    wide  = sub ? x - y - cin : x + y + cin;
    exact = sub ? sx - sy - cin : sx + sy + cin;
    r = wide[W-1:0];
    c = sub ? (wide >= 0) : (wide > MAX_U);
    v = (exact > MAX_S) || (exact < MIN_S);
  endfunction

  function automatic aluPkg::execRspT modelExec(input aluPkg::execReqT rq,
      input aluPkg::flagsT f);
    aluPkg::execRspT rsp;
    aluPkg::flagsT   nf;
    logic [W-1:0]    r;
    logic [2*W-1:0]  product;
    longint          sa;
    longint          sb;
    longint          ua;
    longint          ub;
    longint          exact;
    logic            sat;
    int              sh;
    nf  = f;
    r   = '0;
    sat = 1'b0;
    sa  = $signed(rq.a);
    sb  = $signed(rq.b);
    ua  = rq.a;
    ub  = rq.b;
    sh  = rq.b[4:0];
    product = ua * ub;
    case (rq.op)
      aluPkg::ADD, aluPkg::CMN: addSub(ua, ub, sa, sb, 0, 1'b0, r, nf.c, nf.v);
      aluPkg::ADC: addSub(ua, ub, sa, sb, longint'(f.c), 1'b0, r, nf.c, nf.v);
      aluPkg::SUB, aluPkg::CMP: addSub(ua, ub, sa, sb, 0, 1'b1, r, nf.c, nf.v);
      aluPkg::SBC: addSub(ua, ub, sa, sb, longint'(!f.c), 1'b1, r, nf.c, nf.v);
      aluPkg::RSB: addSub(ub, ua, sb, sa, 0, 1'b1, r, nf.c, nf.v);
      aluPkg::QADD, aluPkg::QSUB: begin
        exact = (rq.op == aluPkg::QADD) ? sa + sb : sa - sb;
        sat   = (exact > MAX_S) || (exact < MIN_S);
        r = (exact > MAX_S) ? W'(MAX_S) : (exact < MIN_S) ? W'(MIN_S) : exact[W-1:0];
      end
      aluPkg::MUL:                 r = product[W-1:0];
      aluPkg::UDIV:                r = (rq.b == 0) ? '0 : rq.a / rq.b;
      aluPkg::SDIV:                r = (rq.b == 0) ? '0 : W'(sa / sb);
      aluPkg::AND_OP, aluPkg::TST: r = rq.a & rq.b;
      aluPkg::BIC:                 r = rq.a & ~rq.b;
      aluPkg::ORR:                 r = rq.a | rq.b;
      aluPkg::ORN:                 r = rq.a | ~rq.b;
      aluPkg::EOR, aluPkg::TEQ:    r = rq.a ^ rq.b;
      aluPkg::MOV:                 r = rq.b;
      aluPkg::LSHIFT: begin
        r = rq.a << sh;
        if (sh != 0) nf.c = rq.a[W - sh];
      end
      aluPkg::RSHIFT: begin
        r = rq.a >> sh;
        if (sh != 0) nf.c = rq.a[sh - 1];
      end
      aluPkg::ASHIFT: begin
        r = $signed(rq.a) >>> sh;
        if (sh != 0) nf.c = rq.a[sh - 1];
      end
      aluPkg::ROR: begin
        r = (rq.a >> sh) | (rq.a << (W - sh));
        if (sh != 0) nf.c = rq.a[sh - 1];
      end
      aluPkg::RRX: begin
        r    = {f.c, rq.a[W-1:1]};
        nf.c = rq.a[0];
      end
      default: r = '0;
    endcase
    nf.n = r[W-1];
    nf.z = (r == '0);
    nf.q = f.q | sat;
    rsp.result = (rq.op == aluPkg::MUL) ? product : {{W{1'b0}}, r};
    rsp.flags  = rq.setFlags ? nf : f;
    return rsp;
  endfunction

  task automatic expectField(input string name, input logic [2*W-1:0] got,
      input logic [2*W-1:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compareResponse(input aluPkg::execRspT e);
    expectField("rspData.result", rspData.result, e.result);
    expectField("rspData.flags.n", rspData.flags.n, e.flags.n);
    expectField("rspData.flags.z", rspData.flags.z, e.flags.z);
    expectField("rspData.flags.c", rspData.flags.c, e.flags.c);
    expectField("rspData.flags.v", rspData.flags.v, e.flags.v);
    expectField("rspData.flags.q", rspData.flags.q, e.flags.q);
  endtask

  task automatic resetDut();
    rstN <= 1'b0;
    modelFlags = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    assert (!ack) else begin
      $display("ERROR: ack is high right after reset at %0t", $time);
      errors++;
    end
  endtask

  // One full four-phase cycle
  // A negative hold count draws a random back-pressure
  task automatic executeOp(input aluPkg::aluOpT code, input logic [W-1:0] opA,
      input logic [W-1:0] opB, input logic setFlags = 1'b1, input int holdCycles = -1);
    aluPkg::execReqT rq;
    int              hold;
    rq = '{op: code, a: opA, b: opB, setFlags: setFlags};
    expected.push_back(modelExec(rq, modelFlags));
    modelFlags = expected[$].flags;
    requests++;
    if (holdCycles >= 0) hold = holdCycles;
    else hold = (($random(seed) & 3) == 0) ? ($random(seed) & 7) : 0;
    @(posedge clk);
    req     <= 1'b1;
    reqData <= rq;
    @(posedge clk);
    while (!ack) @(posedge clk);
    repeat (hold) begin
      @(posedge clk);
      assert (ack) else begin
        $display("ERROR: ack dropped at %0t while req was still high", $time);
        errors++;
      end
    end
    req <= 1'b0;
    @(posedge clk);
    while (ack) @(posedge clk);
  endtask

  // Checks each response on the ack rise and its stability while ack stays up
  always @(posedge clk) begin
    if (!rstN) begin
      ackPrev = 1'b0;
    end else begin
      if (ack && !ackPrev) begin
        responses++;
        heldRsp = rspData;
        if (expected.size() == 0) begin
          $display("ERROR: response at %0t with no request outstanding", $time);
          errors++;
        end else begin
          compareResponse(expected.pop_front());
        end
      end else if (ack) begin
        compareResponse(heldRsp);
      end
      ackPrev = ack;
    end
  end

  initial begin
    aluPkg::aluOpT op;
    rstN       = 1'b0;
    req        = 1'b0;
    reqData    = '0;
    modelFlags = '0;
    resetDut();

    // Add and subtract family on edge and random operands
    foreach (addOps[k]) begin
      for (int i = 0; i < 7; i++) begin
        executeOp(addOps[k], edgeVals[i], edgeVals[(i * 3 + k) % 7]);
        executeOp(addOps[k], $random(seed), $random(seed));
      end
    end
    // Carry chain through ADC and SBC
    for (int i = 0; i < 4; i++) begin
      executeOp(aluPkg::ADD, 32'hffffffff, i);
      executeOp(aluPkg::ADC, $random(seed), $random(seed));
      executeOp(aluPkg::SUB, i, 32'd1);
      executeOp(aluPkg::SBC, $random(seed), $random(seed));
    end

    // Saturation sets Q and ordinary ops must keep it
    executeOp(aluPkg::QADD, 32'h7fffffff, 32'd1);
    executeOp(aluPkg::QADD, 32'h80000000, 32'hffffffff);
    executeOp(aluPkg::QSUB, 32'h80000000, 32'd1);
    executeOp(aluPkg::QSUB, 32'h7fffffff, 32'hffffffff);
    for (int i = 0; i < 8; i++) begin
      executeOp(aluPkg::QADD, $random(seed), $random(seed));
      executeOp(aluPkg::ADD, i, i);
    end
    resetDut();
    executeOp(aluPkg::QSUB, 32'd5, 32'd3);

    foreach (logicOps[k]) begin
      // C and V alternate between all clear and all set
      executeOp(aluPkg::SUB, (k % 2) ? 32'h80000000 : 32'h0, 32'd1);
      repeat (4) executeOp(logicOps[k], $random(seed), $random(seed));
    end
    executeOp(aluPkg::AND_OP, 32'hf0f0f0f0, 32'h0f0f0f0f);
    executeOp(aluPkg::MOV, 32'h0, 32'h80000000);

    // Every opcode with flag update disabled
    executeOp(aluPkg::SUB, 32'h80000000, 32'd1);
    op = op.first();
    do begin
      executeOp(op, $random(seed), $random(seed), 1'b0);
      op = op.next();
    end while (op != op.first());

    foreach (shiftOps[k]) begin
      for (int j = 0; j < 5; j++) begin
        executeOp(aluPkg::CMP, (j + k) % 2, 32'd1);
        executeOp(shiftOps[k], $random(seed),
                  (j < 3) ? shiftAmts[j] | ($random(seed) & 32'hffffffe0) : $random(seed));
      end
    end

    executeOp(aluPkg::MUL, 32'hffffffff, 32'hffffffff);
    repeat (6) executeOp(aluPkg::MUL, $random(seed), $random(seed));
    foreach (edgeVals[i]) begin
      executeOp(aluPkg::UDIV, $random(seed), edgeVals[i]);
      executeOp(aluPkg::SDIV, $random(seed), edgeVals[i]);
    end
    repeat (6) begin
      executeOp(aluPkg::UDIV, $random(seed), $random(seed) >>> ($random(seed) & 31));
      executeOp(aluPkg::SDIV, $random(seed), $random(seed) >>> ($random(seed) & 31));
    end
    executeOp(aluPkg::SDIV, 32'h80000000, 32'hffffffff);
    executeOp(aluPkg::SDIV, 32'hfffffff9, 32'd2);

    // Long back-pressure on both response paths
    for (int i = 0; i < 6; i++) begin
      executeOp(aluPkg::UDIV, $random(seed), i + 1, 1'b1, 3 + i);
      executeOp(aluPkg::MUL, $random(seed), $random(seed), 1'b1, 3 + i);
    end

    repeat (4) @(posedge clk);
    assert (expected.size() == 0 && responses == requests) else begin
      $display("ERROR: %0d requests received %0d responses", requests, responses);
      errors++;
    end
    $display("Summary: %0d requests, %0d responses, %0d errors", requests, responses, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: watchdog expired, the DUT stopped completing handshakes");
    $display("Summary: %0d requests, %0d responses, %0d errors", requests, responses, errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/aluPkg.sv
design/alu.sv
design/divider.sv
design/statusRegister.sv
design/execUnit.sv
verif/execUnitTb.sv
